//--- hdl/i2c_pkg.sv
// I2C bus definitions for the board interface.
// Bus count, synchronizer depth and the bus conditions seen by the resolver.

package i2c_pkg;

  // Number of I2C buses on the board.
  localparam int unsigned NumI2c = 2;

  // Flops between the resolved line and the controller input.
  localparam int unsigned SyncStages = 2;

  // Bus condition seen in one cycle of synchronized SCL and SDA.
  // Start and stop only count while SCL is high.
  typedef enum logic [1:0] {
    // SCL high, SDA steady.
    CondIdle  = 2'd0,
    // SDA falls while SCL is high.
    CondStart = 2'd1,
    // SDA rises while SCL is high.
    CondStop  = 2'd2,
    // SCL low, so SDA may change freely.
    CondData  = 2'd3
  } i2c_cond_e;

endpackage

//--- hdl/fault_pkg.sv
// Fault indicator definitions for the board interface.
// Cause count, cause codes and the LED blink rate.

package fault_pkg;

  // Number of hardware fault causes.
  localparam int unsigned FaultWidth = 9;

  // Cause code of a report.
  // Each value equals the bit index of the cause in the fault vector.
  typedef enum logic [3:0] {
    FaultBounds              = 4'd0,
    FaultTag                 = 4'd1,
    FaultSeal                = 4'd2,
    FaultPermitExecute       = 4'd3,
    FaultPermitLoad          = 4'd4,
    FaultPermitStore         = 4'd5,
    FaultPermitStoreCap      = 4'd6,
    FaultPermitStoreLocalCap = 4'd7,
    // Access to system registers.
    FaultPermitAccSys        = 4'd8
  } fault_cause_e;

  // Default LED half-period in clock cycles.
  localparam int unsigned BlinkDivDefault = 8;

endpackage

//--- hdl/i2c_line_resolver.sv
// I2C line resolver for one bus.
// Wired-AND of controller and device drives, synchronized read-back
// and a bus-busy level from START and STOP.

`timescale 1ns/100ps

module i2c_line_resolver import i2c_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  // Controller side drives open-drain style.
  input  logic scl_o_i,
  input  logic scl_en_i,
  input  logic sda_o_i,
  input  logic sda_en_i,

  // External device pulls. A 1 pulls the line low.
  input  logic dev_scl_pull_i,
  input  logic dev_sda_pull_i,

  output logic scl_line_o,
  output logic sda_line_o,
  output logic scl_in_o,
  output logic sda_in_o,
  output logic bus_busy_o
);

  logic                  scl_line;
  logic                  sda_line;
  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_in;
  logic                  sda_in;
  logic                  sda_prev_q;
  i2c_cond_e             cond;
  logic                  busy_d;
  logic                  busy_q;

  // Line is low if either side pulls it.
  // Controller pulls only when enabled with a low output.
  assign scl_line = ~((scl_en_i & ~scl_o_i) | dev_scl_pull_i);
  assign sda_line = ~((sda_en_i & ~sda_o_i) | dev_sda_pull_i);

  assign scl_line_o = scl_line;
  assign sda_line_o = sda_line;

  // Synchronizers.
  // Reset to the idle level of a pulled-up bus.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_line};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_line};
    end
  end

  assign scl_in = scl_sync_q[SyncStages-1];
  assign sda_in = sda_sync_q[SyncStages-1];

  assign scl_in_o = scl_in;
  assign sda_in_o = sda_in;

  // Classify this cycle from the synchronized levels.
  always_comb begin
    cond = CondIdle;
    if (!scl_in) begin
      cond = CondData;
    end else if (sda_prev_q && !sda_in) begin
      cond = CondStart;
    end else if (!sda_prev_q && sda_in) begin
      cond = CondStop;
    end
  end

  // START sets busy, STOP clears it.
  always_comb begin
    case (cond)
      CondStart: busy_d = 1'b1;
      CondStop:  busy_d = 1'b0;
      default:   busy_d = busy_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_prev_q <= 1'b1;
      busy_q     <= 1'b0;
    end else begin
      sda_prev_q <= sda_in;
      busy_q     <= busy_d;
    end
  end

  assign bus_busy_o = busy_q;

endmodule

//--- hdl/fault_reporter.sv
// Fault reporter.
// Latches each fault cause once, queues it and reports the lowest
// pending cause as a one-cycle pulse with its cause code.

`timescale 1ns/100ps

module fault_reporter import fault_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Fault lines as levels, pulses or LED-modulated signals.
  input  logic [FaultWidth-1:0] fault_i,

  output logic                  report_o,
  output fault_cause_e          report_cause_o,
  output logic [FaultWidth-1:0] fault_seen_o
);

  logic [FaultWidth-1:0] pending_d;
  logic [FaultWidth-1:0] pending_q;
  logic [FaultWidth-1:0] seen_d;
  logic [FaultWidth-1:0] seen_q;
  logic [FaultWidth-1:0] fresh;
  logic [FaultWidth-1:0] pick;
  logic                  any_pending;
  fault_cause_e          pick_cause;
  logic                  report_q;
  fault_cause_e          report_cause_q;

  // New causes only.
  // A cause already queued or reported is ignored, so a modulated line
  // cannot raise a second report.
  assign fresh = fault_i & ~pending_q & ~seen_q;

  assign any_pending = |pending_q;

  // Isolate the lowest pending bit.
  assign pick = pending_q & (~pending_q + 1'b1);

  // Encode the picked bit as a cause code.
  always_comb begin
    pick_cause = FaultBounds;
    for (int unsigned i = 0; i < FaultWidth; i++) begin
      if (pick[i]) begin
        pick_cause = fault_cause_e'(i);
      end
    end
  end

  // Picked bit leaves pending and joins seen.
  assign pending_d = (pending_q & ~pick) | fresh;
  assign seen_d    = seen_q | pick;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      seen_q    <= '0;
      report_q  <= 1'b0;
    end else begin
      pending_q <= pending_d;
      seen_q    <= seen_d;
      // One report per cycle while anything is queued.
      report_q  <= any_pending;
    end
  end

  // Cause code of the picked bit, captured with each report.
  always_ff @(posedge clk_i) begin
    if (any_pending) begin
      report_cause_q <= pick_cause;
    end
  end

  assign report_o       = report_q;
  assign report_cause_o = report_cause_q;
  assign fault_seen_o   = seen_q;

endmodule

//--- hdl/fault_led_driver.sv
// Fault LED driver.
// Blinks one LED for every fault cause that has been reported.

`timescale 1ns/100ps

module fault_led_driver import fault_pkg::*; #(
  // Half-period of the blink in clock cycles.
  parameter int unsigned BlinkDiv = BlinkDivDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [FaultWidth-1:0] fault_seen_i,
  output logic [FaultWidth-1:0] fault_led_o
);

  localparam int unsigned CntWidth = (BlinkDiv > 1) ? $clog2(BlinkDiv) : 1;

  logic [CntWidth-1:0]   cnt_q;
  logic                  cnt_wrap;
  logic                  blink_q;
  logic [FaultWidth-1:0] led_q;

  // End of a half-period.
  assign cnt_wrap = (cnt_q == CntWidth'(BlinkDiv - 1));

  // Phase counter and blink flag.
  // Flag starts dark and toggles once per half-period.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      blink_q <= 1'b0;
    end else if (cnt_wrap) begin
      cnt_q   <= '0;
      blink_q <= ~blink_q;
    end else begin
      cnt_q   <= cnt_q + 1'b1;
    end
  end

  // Registered LED outputs.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      led_q <= '0;
    end else begin
      led_q <= fault_seen_i & {FaultWidth{blink_q}};
    end
  end

  assign fault_led_o = led_q;

endmodule

//--- hdl/board_io_top.sv
// Board interface top level.
// Resolves the I2C buses and turns fault lines into reports and LEDs.

`timescale 1ns/100ps

module board_io_top import i2c_pkg::*, fault_pkg::*; #(
  parameter int unsigned NumI2c   = i2c_pkg::NumI2c,
  parameter int unsigned BlinkDiv = BlinkDivDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // I2C controller drives.
  input  logic [NumI2c-1:0]     scl_o_i,
  input  logic [NumI2c-1:0]     scl_en_i,
  input  logic [NumI2c-1:0]     sda_o_i,
  input  logic [NumI2c-1:0]     sda_en_i,

  // I2C device pulls.
  input  logic [NumI2c-1:0]     dev_scl_pull_i,
  input  logic [NumI2c-1:0]     dev_sda_pull_i,

  // Resolved lines and controller read-back.
  output logic [NumI2c-1:0]     scl_line_o,
  output logic [NumI2c-1:0]     sda_line_o,
  output logic [NumI2c-1:0]     scl_in_o,
  output logic [NumI2c-1:0]     sda_in_o,
  output logic [NumI2c-1:0]     bus_busy_o,

  // Fault lines and reports.
  input  logic [FaultWidth-1:0] fault_i,
  output logic                  report_o,
  output fault_cause_e          report_cause_o,
  output logic [FaultWidth-1:0] fault_seen_o,
  output logic [FaultWidth-1:0] fault_led_o
);

  logic [FaultWidth-1:0] fault_seen;

  // One resolver per bus.
  for (genvar b = 0; b < NumI2c; b++) begin : gen_i2c
    i2c_line_resolver u_i2c_line_resolver (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .scl_o_i        (scl_o_i[b]),
      .scl_en_i       (scl_en_i[b]),
      .sda_o_i        (sda_o_i[b]),
      .sda_en_i       (sda_en_i[b]),
      .dev_scl_pull_i (dev_scl_pull_i[b]),
      .dev_sda_pull_i (dev_sda_pull_i[b]),
      .scl_line_o     (scl_line_o[b]),
      .sda_line_o     (sda_line_o[b]),
      .scl_in_o       (scl_in_o[b]),
      .sda_in_o       (sda_in_o[b]),
      .bus_busy_o     (bus_busy_o[b])
    );
  end

  // First-occurrence fault reports.
  fault_reporter u_fault_reporter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fault_i        (fault_i),
    .report_o       (report_o),
    .report_cause_o (report_cause_o),
    .fault_seen_o   (fault_seen)
  );

  assign fault_seen_o = fault_seen;

  // Blinking LEDs for reported causes.
  fault_led_driver #(
    .BlinkDiv (BlinkDiv)
  ) u_fault_led_driver (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fault_seen_i (fault_seen),
    .fault_led_o  (fault_led_o)
  );

endmodule

//--- bench/tb_board_io_top.sv
// Testbench for the board interface top level.
// Random I2C drives and fault bursts, checked against a cycle model.

`timescale 1ns/100ps

module tb_board_io_top import i2c_pkg::*, fault_pkg::*;;

  localparam int unsigned BlinkDiv    = 4;
  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned DriveDelay  = 2;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned StepHold    = 5;
  localparam int unsigned ScriptSteps = 7;
  localparam int unsigned Rounds      = 4;
  localparam int unsigned RoundCycles = 150;
  localparam int unsigned MidReset    = 4;
  localparam int unsigned TotalCycles = ResetCycles + 1 + ScriptSteps * StepHold
                                        + Rounds * (RoundCycles + MidReset);
  localparam int unsigned TimeoutNs   = (TotalCycles + 100) * ClkPeriod;

  logic                  clk_i;
  logic                  rst_ni;
  logic [NumI2c-1:0]     scl_o_i, scl_en_i, sda_o_i, sda_en_i;
  logic [NumI2c-1:0]     dev_scl_pull_i, dev_sda_pull_i;
  logic [NumI2c-1:0]     scl_line_o, sda_line_o, scl_in_o, sda_in_o, bus_busy_o;
  logic [FaultWidth-1:0] fault_i;
  logic                  report_o;
  fault_cause_e          report_cause_o;
  logic [FaultWidth-1:0] fault_seen_o;
  logic [FaultWidth-1:0] fault_led_o;

  // Model state.
  logic [NumI2c-1:0]     m_scl_s1, m_scl_s2, m_sda_s1, m_sda_s2, m_sda_prev, m_busy;
  logic [FaultWidth-1:0] m_pending, m_seen, m_led;
  logic                  m_report;
  fault_cause_e          m_cause;
  int unsigned           m_cnt;
  logic                  m_blink;
  // Causes reported by the DUT since the last reset.
  logic [FaultWidth-1:0] reported_mask;

  int unsigned err_count   = 0;
  int unsigned check_count = 0;

  board_io_top #(
    .NumI2c   (NumI2c),
    .BlinkDiv (BlinkDiv)
  ) i_dut (
    .clk_i, .rst_ni, .scl_o_i, .scl_en_i, .sda_o_i, .sda_en_i,
    .dev_scl_pull_i, .dev_sda_pull_i, .scl_line_o, .sda_line_o,
    .scl_in_o, .sda_in_o, .bus_busy_o, .fault_i, .report_o,
    .report_cause_o, .fault_seen_o, .fault_led_o
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cause(input fault_cause_e got, input fault_cause_e exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_vec(input logic [FaultWidth-1:0] got,
                           input logic [FaultWidth-1:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Line is low if the controller drives low or the device pulls.
  function automatic logic line_level(input logic o, input logic en, input logic pull);
    return !((en && !o) || pull);
  endfunction

  // Start and stop only count while synchronized SCL is high.
  function automatic i2c_cond_e classify(input logic scl, input logic sda, input logic prev);
    if (!scl) return CondData;
    if (prev && !sda) return CondStart;
    if (!prev && sda) return CondStop;
    return CondIdle;
  endfunction

  task automatic model_reset;
    m_scl_s1 = '1;
    m_scl_s2 = '1;
    m_sda_s1 = '1;
    m_sda_s2 = '1;
    m_sda_prev = '1;
    m_busy = '0;
    m_pending = '0;
    m_seen = '0;
    m_led = '0;
    m_report = 1'b0;
    m_cnt = 0;
    m_blink = 1'b0;
    reported_mask = '0;
  endtask

  // One rising edge of the model on the inputs held before it.
  task automatic model_clock;
    logic [FaultWidth-1:0] fresh;
    logic [FaultWidth-1:0] pick;
    i2c_cond_e             cond;
    int                    lowest;
    for (int b = 0; b < NumI2c; b++) begin
      cond = classify(m_scl_s2[b], m_sda_s2[b], m_sda_prev[b]);
      if (cond == CondStart) m_busy[b] = 1'b1;
      else if (cond == CondStop) m_busy[b] = 1'b0;
      m_sda_prev[b] = m_sda_s2[b];
      m_scl_s2[b] = m_scl_s1[b];
      m_sda_s2[b] = m_sda_s1[b];
      m_scl_s1[b] = line_level(scl_o_i[b], scl_en_i[b], dev_scl_pull_i[b]);
      m_sda_s1[b] = line_level(sda_o_i[b], sda_en_i[b], dev_sda_pull_i[b]);
    end
    // Lowest pending cause goes out first.
    fresh = fault_i & ~m_pending & ~m_seen;
    pick = '0;
    lowest = -1;
    for (int i = 0; i < FaultWidth; i++) begin
      if (m_pending[i] && lowest < 0) lowest = i;
    end
    if (lowest >= 0) pick[lowest] = 1'b1;
    m_led = m_seen & {FaultWidth{m_blink}};
    m_report = (lowest >= 0);
    if (lowest >= 0) m_cause = fault_cause_e'(lowest);
    m_pending = (m_pending & ~pick) | fresh;
    m_seen = m_seen | pick;
    // Blink phase flips every BlinkDiv cycles.
    if (m_cnt == BlinkDiv - 1) begin
      m_cnt = 0;
      m_blink = ~m_blink;
    end else begin
      m_cnt++;
    end
  endtask

  task automatic check_outputs;
    int idx;
    for (int b = 0; b < NumI2c; b++) begin
      check_bit(scl_line_o[b], line_level(scl_o_i[b], scl_en_i[b], dev_scl_pull_i[b]),
                $sformatf("bus %0d scl_line", b));
      check_bit(sda_line_o[b], line_level(sda_o_i[b], sda_en_i[b], dev_sda_pull_i[b]),
                $sformatf("bus %0d sda_line", b));
      check_bit(scl_in_o[b], m_scl_s2[b], $sformatf("bus %0d scl_in", b));
      check_bit(sda_in_o[b], m_sda_s2[b], $sformatf("bus %0d sda_in", b));
      check_bit(bus_busy_o[b], m_busy[b], $sformatf("bus %0d bus_busy", b));
    end
    check_bit(report_o, m_report, "report");
    if (m_report) check_cause(report_cause_o, m_cause, "report_cause");
    check_vec(fault_seen_o, m_seen, "fault_seen");
    check_vec(fault_led_o, m_led, "fault_led");
    // A cause may be reported only once per reset.
    if (report_o === 1'b1 && report_cause_o < FaultWidth) begin
      idx = int'(report_cause_o);
      if (reported_mask[idx]) begin
        err_count++;
        $display("[FAIL] %0t ns cause %s reported twice", $time, report_cause_o.name());
      end
      reported_mask[idx] = 1'b1;
    end
  endtask

  // Values that hold right after reset.
  task automatic check_reset_state;
    check_bit(report_o, 1'b0, "report after reset");
    check_vec(fault_seen_o, '0, "fault_seen after reset");
    check_vec(fault_led_o, '0, "fault_led after reset");
    for (int b = 0; b < NumI2c; b++) begin
      check_bit(bus_busy_o[b], 1'b0, $sformatf("bus %0d busy after reset", b));
      check_bit(scl_in_o[b], 1'b1, $sformatf("bus %0d scl_in after reset", b));
      check_bit(sda_in_o[b], 1'b1, $sformatf("bus %0d sda_in after reset", b));
    end
  endtask

  // Edge, model update, then the drive point.
  task automatic advance;
    @(posedge clk_i);
    if (rst_ni) model_clock();
    #(DriveDelay);
  endtask

  task automatic settle;
    #1;
    check_outputs();
  endtask

  // Controller holds both lines of every bus for a few cycles.
  task automatic drive_bus(input logic scl, input logic sda, input logic exp_busy);
    repeat (StepHold) begin
      advance();
      scl_en_i = '1;
      sda_en_i = '1;
      scl_o_i = {NumI2c{scl}};
      sda_o_i = {NumI2c{sda}};
      dev_scl_pull_i = '0;
      dev_sda_pull_i = '0;
      fault_i = '0;
      settle();
    end
    for (int b = 0; b < NumI2c; b++) begin
      check_bit(bus_busy_o[b], exp_busy, $sformatf("bus %0d scripted busy", b));
    end
  endtask

  task automatic random_cycle;
    advance();
    scl_o_i = NumI2c'($urandom);
    scl_en_i = NumI2c'($urandom);
    sda_o_i = NumI2c'($urandom);
    sda_en_i = NumI2c'($urandom);
    // Device pulls about a quarter of the time.
    dev_scl_pull_i = NumI2c'($urandom & $urandom);
    dev_sda_pull_i = NumI2c'($urandom & $urandom);
    // Sparse bursts, held levels and quiet cycles.
    case ($urandom_range(0, 7))
      0: fault_i = FaultWidth'($urandom & $urandom & $urandom);
      1, 2: fault_i = fault_i;
      default: fault_i = '0;
    endcase
    settle();
  endtask

  task automatic pulse_reset;
    advance();
    rst_ni = 1'b0;
    model_reset();
    settle();
    check_reset_state();
    repeat (MidReset - 2) begin
      advance();
      settle();
      check_reset_state();
    end
    advance();
    rst_ni = 1'b1;
    settle();
  endtask

  // Watchdog.
  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns.", TimeoutNs);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'h4b5b));
    rst_ni = 1'b0;
    scl_o_i = '1;
    scl_en_i = '0;
    sda_o_i = '1;
    sda_en_i = '0;
    dev_scl_pull_i = '0;
    dev_sda_pull_i = '0;
    fault_i = '0;
    model_reset();
    repeat (ResetCycles) begin
      advance();
      settle();
      check_reset_state();
    end
    advance();
    rst_ni = 1'b1;
    settle();
    // START, data while SCL is low, then STOP.
    drive_bus(1'b1, 1'b1, 1'b0);
    drive_bus(1'b1, 1'b0, 1'b1);
    drive_bus(1'b0, 1'b0, 1'b1);
    drive_bus(1'b0, 1'b1, 1'b1);
    drive_bus(1'b0, 1'b0, 1'b1);
    drive_bus(1'b1, 1'b0, 1'b1);
    drive_bus(1'b1, 1'b1, 1'b0);
    repeat (Rounds) begin
      repeat (RoundCycles) random_cycle();
      pulse_reset();
    end
    $display("Checks: %0d  Errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/i2c_pkg.sv
hdl/fault_pkg.sv
hdl/i2c_line_resolver.sv
hdl/fault_reporter.sv
hdl/fault_led_driver.sv
hdl/board_io_top.sv
bench/tb_board_io_top.sv

//--- Bender.yml
package:
  name: board_io

sources:
  # Design sources, used for synthesis and simulation.
  - target: any(synthesis, simulation)
    files:
      - hdl/i2c_pkg.sv
      - hdl/fault_pkg.sv
      - hdl/i2c_line_resolver.sv
      - hdl/fault_reporter.sv
      - hdl/fault_led_driver.sv
      - hdl/board_io_top.sv

  # Testbench, simulation only.
  - target: simulation
    files:
      - bench/tb_board_io_top.sv
